// ==== compile.f ====
+incdir+sim
source/tap_pkg.sv
source/ejtag_pkg.sv
source/tap_controller.sv
source/tap_instruction.sv
source/ejtag_scan.sv
source/ejtag_control_reg.sv
source/ejtag_top.sv
sim/ejtag_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ejtag_tb -f compile.f -o ejtag_sim

out=$(./obj_dir/ejtag_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

// ==== sim/ejtag_tb_tasks.svh ====
`ifndef EJTAG_TB_TASKS_SVH
`define EJTAG_TB_TASKS_SVH

// ##########################################################
// TAP driving with one TCK per step
// ##########################################################

// Samples the outputs at the falling edge, then drives tms and tdi.
task automatic tap_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
  @(negedge JTAG_CLOCK);
  tdo_v       = tdo;
  upd_sampled = upd;
  if (upd.update_data) n_upd_data++;
  if (upd.update_addr) n_upd_addr++;
  if (upd.update_ctl) n_upd_ctl++;
  if (pctrace_on) n_pctrace++;
  tms = tms_v;
  tdi = tdi_v;
endtask

task automatic tap_reset();
  logic b;
  repeat (5) tap_step(1'b1, 1'b0, b); // Test-Logic-Reset from any state.
  tap_step(1'b0, 1'b0, b);            // Run-Test/Idle.
endtask

task automatic idle_cycles(input int n);
  logic b;
  repeat (n) tap_step(1'b0, 1'b0, b);
endtask

task automatic clear_counts();
  n_upd_data = 0;
  n_upd_addr = 0;
  n_upd_ctl  = 0;
  n_pctrace  = 0;
endtask

// Starts and ends in Run-Test/Idle.
task automatic ir_scan(input logic [4:0] ins, output logic [4:0] cap);
  logic b;
  tap_step(1'b1, 1'b0, b); // Select-DR.
  tap_step(1'b1, 1'b0, b); // Select-IR.
  tap_step(1'b0, 1'b0, b); // Capture-IR.
  tap_step(1'b0, 1'b0, b); // Shift-IR.
  for (int i = 0; i < 5; i++) begin
    tap_step(i == 4, ins[i], b);
    cap[i] = b;
  end
  tap_step(1'b1, 1'b0, b); // Update-IR.
  tap_step(1'b0, 1'b0, b);
endtask

// LSB first in both directions. The upd value is sampled during Update-DR.
task automatic dr_scan(input logic [95:0] din, input int len, output logic [95:0] dout,
                       output ejtag_pkg::scan_upd_t upd_at_update);
  logic b;
  dout = '0;
  tap_step(1'b1, 1'b0, b); // Select-DR.
  tap_step(1'b0, 1'b0, b); // Capture-DR.
  tap_step(1'b0, 1'b0, b); // Shift-DR.
  for (int i = 0; i < len; i++) begin
    tap_step(i == len - 1, din[i], b);
    dout[i] = b;
  end
  tap_step(1'b1, 1'b0, b); // Update-DR.
  tap_step(1'b0, 1'b0, b);
  upd_at_update = upd_sampled;
endtask

task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
  end
endtask

`endif

// ==== sim/ejtag_tb.sv ====
`timescale 1ns/1ps

module ejtag_tb;

  localparam int          CLK_PERIOD      = 40;
  localparam int          NUM_TESTS       = 6;
  localparam int          CYCLES_PER_TEST = 400;
  localparam logic [31:0] WRITE_MASK      = 32'h0007_8000;
  localparam logic [4:0]  IR_CAPTURE_EXP  = 5'b00001;
  localparam logic [4:0]  IDCODE_INS      = 5'b00001; // Not decoded, so it runs through bypass.

  logic                 JTAG_CLOCK;
  logic                 RESET_D1_JR_N;
  logic                 tms;
  logic                 tdi;
  logic                 tdo;
  logic [31:0]          proc_data;
  logic [31:0]          proc_addr;
  logic [31:0]          dma_data;
  logic [31:0]          dma_addr;
  logic [31:0]          proc_status;
  ejtag_pkg::cfg_t      cfg;
  ejtag_pkg::scan_out_t scan;
  ejtag_pkg::scan_upd_t upd;
  logic [31:0]          ejc_ctl;
  logic                 pctrace_on;

  ejtag_pkg::scan_upd_t upd_sampled;
  int                   n_upd_data, n_upd_addr, n_upd_ctl, n_pctrace;
  int                   error_count, check_count, errs_at_start;
  logic [31:0]          ctl_written; // Last control word scanned in.

  ejtag_top #(
    .CTL_WRITE_MASK (WRITE_MASK)
  ) i_ejtag_top (
    .JTAG_CLOCK    (JTAG_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .tms           (tms),
    .tdi           (tdi),
    .tdo           (tdo),
    .proc_data     (proc_data),
    .proc_addr     (proc_addr),
    .dma_data      (dma_data),
    .dma_addr      (dma_addr),
    .proc_status   (proc_status),
    .cfg           (cfg),
    .scan          (scan),
    .upd           (upd),
    .ejc_ctl       (ejc_ctl),
    .pctrace_on    (pctrace_on)
  );

  `include "ejtag_tb_tasks.svh"

  initial begin
    JTAG_CLOCK = 1'b0;
    forever #(CLK_PERIOD / 2) JTAG_CLOCK = ~JTAG_CLOCK;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    $display("Finished with errors");
    $finish;
  end

  // ##########################################################
  // Reference model
  // ##########################################################

  function automatic logic [31:0] ref_impcode(input ejtag_pkg::cfg_t c);
    logic [31:0] w;
    w        = '0;
    w[10:8]  = {1'b0, c.n_minus1};
    w[13:11] = {1'b0, c.m_log2};
    w[16]    = 1'b1;
    w[23]    = 1'b1;
    w[26]    = c.ej_dis;
    w[27]    = c.asid16;
    return w;
  endfunction

  function automatic logic [31:0] ref_capture(input logic dma, input logic [31:0] from_proc,
                                              input logic [31:0] from_dma);
    return dma ? from_dma : from_proc;
  endfunction

  function automatic logic [31:0] ref_control(input logic [31:0] written,
                                              input logic [31:0] status);
    return (written & WRITE_MASK) | (status & ~WRITE_MASK);
  endfunction

  function automatic logic dma_selected(input logic [31:0] written, input logic [31:0] status);
    logic [31:0] w;
    w = ref_control(written, status);
    return w[ejtag_pkg::CTL_DMAACC];
  endfunction

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: %s", num, name, (error_count == errs_at_start) ? "ok" : "FAILED");
    errs_at_start = error_count;
  endtask

  // One register write with the strobe watched over the whole scan.
  task automatic single_write(input logic [4:0] ins, input ejtag_pkg::scan_upd_t exp_upd);
    logic [4:0]           cap;
    logic [95:0]          dout;
    logic [31:0]          w;
    logic [31:0]          seen;
    ejtag_pkg::scan_upd_t u;
    w = $urandom;
    ir_scan(ins, cap);
    clear_counts();
    dr_scan({64'h0, w}, 32, dout, u);
    idle_cycles(1);
    if (ins == ejtag_pkg::INS_DATA) begin
      seen = scan.data;
    end else if (ins == ejtag_pkg::INS_ADDRESS) begin
      seen = scan.addr;
    end else begin
      seen        = scan.ctl;
      ctl_written = w;
    end
    check("written word on scan", seen, w);
    check("strobes in Update-DR", {29'h0, u}, {29'h0, exp_upd});
    check("update_data cycles", n_upd_data, {31'h0, exp_upd.update_data});
    check("update_addr cycles", n_upd_addr, {31'h0, exp_upd.update_addr});
    check("update_ctl cycles", n_upd_ctl, {31'h0, exp_upd.update_ctl});
  endtask

  // ##########################################################
  // Test sequence
  // ##########################################################

  initial begin
    logic [4:0]           cap;
    logic [95:0]          dout;
    logic [95:0]          w96;
    logic [31:0]          rnd;
    logic                 dma;
    ejtag_pkg::scan_upd_t u;
    void'($urandom(32'h4b14d8a2));
    RESET_D1_JR_N = 1'b0;
    tms           = 1'b1;
    tdi           = 1'b0;
    proc_data     = $urandom;
    proc_addr     = $urandom;
    dma_data      = $urandom;
    dma_addr      = $urandom;
    proc_status   = $urandom;
    cfg           = '0;
    ctl_written   = '0;
    error_count   = 0;
    check_count   = 0;
    errs_at_start = 0;
    clear_counts();
    repeat (10) @(negedge JTAG_CLOCK);
    RESET_D1_JR_N = 1'b1;

    check("data after reset", scan.data, 32'h0);
    check("control word after reset", ejc_ctl, ref_control(32'h0, proc_status));
    tap_reset();
    ir_scan(ejtag_pkg::INS_IMPCODE, cap);
    check("IR capture pattern", {27'h0, cap}, {27'h0, IR_CAPTURE_EXP});
    repeat (3) begin
      rnd = $urandom;
      cfg = rnd[5:0];
      dr_scan('0, 32, dout, u);
      check("implementation word", dout[31:0], ref_impcode(cfg));
    end
    check("no strobe under IMPCODE", n_upd_data + n_upd_addr + n_upd_ctl, 0);
    report_test(1, "IR capture and IMPCODE");

    ir_scan(ejtag_pkg::INS_DATA, cap);
    dr_scan({64'h0, 32'($urandom)}, 32, dout, u);
    dma = dma_selected(ctl_written, proc_status);
    check("processor data capture", dout[31:0], ref_capture(dma, proc_data, dma_data));
    ir_scan(ejtag_pkg::INS_ADDRESS, cap);
    dr_scan({64'h0, 32'($urandom)}, 32, dout, u);
    check("processor address capture", dout[31:0], ref_capture(dma, proc_addr, dma_addr));
    ir_scan(ejtag_pkg::INS_CONTROL, cap);
    rnd = $urandom | 32'h0002_0000; // Sets DMA access.
    dr_scan({64'h0, rnd}, 32, dout, u);
    check("control capture", dout[31:0], ref_control(ctl_written, proc_status));
    ctl_written = rnd;
    dma         = dma_selected(ctl_written, proc_status);
    ir_scan(ejtag_pkg::INS_DATA, cap);
    check("DMA access bit", {31'h0, ejc_ctl[ejtag_pkg::CTL_DMAACC]}, 32'h1);
    dr_scan({64'h0, 32'($urandom)}, 32, dout, u);
    check("DMA data capture", dout[31:0], ref_capture(dma, proc_data, dma_data));
    ir_scan(ejtag_pkg::INS_ADDRESS, cap);
    dr_scan({64'h0, 32'($urandom)}, 32, dout, u);
    check("DMA address capture", dout[31:0], ref_capture(dma, proc_addr, dma_addr));
    report_test(2, "capture source select");

    single_write(ejtag_pkg::INS_DATA, 3'b100);    // {update_data, update_addr, update_ctl}.
    single_write(ejtag_pkg::INS_ADDRESS, 3'b010);
    single_write(ejtag_pkg::INS_CONTROL, 3'b001);
    report_test(3, "single register writes");

    ir_scan(ejtag_pkg::INS_ALL, cap);
    dma = dma_selected(ctl_written, proc_status);
    w96 = {32'($urandom), 32'($urandom), 32'($urandom)}; // Address, data, control.
    clear_counts();
    dr_scan(w96, 96, dout, u);
    idle_cycles(1);
    check("ALL control read-back", dout[31:0], ref_control(ctl_written, proc_status));
    check("ALL data read-back", dout[63:32], ref_capture(dma, proc_data, dma_data));
    check("ALL address read-back", dout[95:64], ref_capture(dma, proc_addr, dma_addr));
    check("ALL control written", scan.ctl, w96[31:0]);
    check("ALL data written", scan.data, w96[63:32]);
    check("ALL address written", scan.addr, w96[95:64]);
    check("ALL strobes", {29'h0, u}, 32'h7);
    check("ALL strobe cycles", n_upd_data + n_upd_addr + n_upd_ctl, 3);
    ctl_written = w96[31:0];
    report_test(4, "ALL chain");

    proc_status = $urandom;
    ir_scan(ejtag_pkg::INS_CONTROL, cap);
    rnd = $urandom;
    dr_scan({64'h0, rnd}, 32, dout, u);
    ctl_written = rnd;
    idle_cycles(1);
    check("control word after write", ejc_ctl, ref_control(ctl_written, proc_status));
    proc_status = $urandom;
    idle_cycles(1);
    check("control word follows status", ejc_ctl, ref_control(ctl_written, proc_status));
    report_test(5, "control word mask");

    ir_scan(ejtag_pkg::INS_PCTRACE, cap);
    clear_counts();
    idle_cycles(4);
    check("PC trace in Run-Test/Idle", n_pctrace, 4);
    dr_scan({64'h0, 32'($urandom)}, 32, dout, u);
    check("PC trace outside Run-Test/Idle", n_pctrace, 5); // Only the idle cycle before Select-DR.
    ir_scan(IDCODE_INS, cap);
    clear_counts();
    idle_cycles(2);
    rnd = $urandom;
    dr_scan({64'h0, rnd}, 33, dout, u);
    check("bypass first bit", {31'h0, dout[0]}, 32'h0);
    check("bypass delayed data", dout[32:1], rnd);
    check("PC trace under IDCODE", n_pctrace, 0);
    report_test(6, "PC trace and bypass");

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== source/ejtag_control_reg.sv ====
`timescale 1ns/1ps

module ejtag_control_reg #(
  parameter logic [31:0] CTL_WRITE_MASK = 32'h0000_0000
) (
  input  logic                 JTAG_CLOCK,
  input  logic                 RESET_D1_JR_N,
  input  ejtag_pkg::scan_upd_t upd,
  input  logic [31:0]          scan_ctl,
  input  logic [31:0]          proc_status,
  output logic [31:0]          ejc_ctl
);

  logic [31:0] ctl_q; // Only the writable bits are ever set here.

  always_ff @(posedge JTAG_CLOCK or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      ctl_q <= '0;
    end else if (upd.update_ctl) begin
      ctl_q <= scan_ctl & CTL_WRITE_MASK;
    end
  end

  // Status bits follow the processor every cycle.
  assign ejc_ctl = ctl_q | (proc_status & ~CTL_WRITE_MASK);

endmodule

// ==== source/ejtag_pkg.sv ====
package ejtag_pkg;

  localparam logic [4:0] INS_IMPCODE = 5'b00011;
  localparam logic [4:0] INS_ADDRESS = 5'b01000;
  localparam logic [4:0] INS_DATA    = 5'b01001;
  localparam logic [4:0] INS_CONTROL = 5'b01010;
  localparam logic [4:0] INS_ALL     = 5'b01011;
  localparam logic [4:0] INS_PCTRACE = 5'b10000;

  localparam int CTL_DMAACC = 17; // DMA-side capture select.

  // Implementation register layout, MSB first.
  typedef struct packed {
    logic [3:0] rsvd_31_28;
    logic       asid16;       // Bit 27.
    logic       ej_dis;       // Bit 26.
    logic [1:0] rsvd_25_24;
    logic       one_23;
    logic [5:0] rsvd_22_17;
    logic       one_16;
    logic [1:0] rsvd_15_14;
    logic [2:0] m_log2;       // Bits 13:11.
    logic [2:0] ejtag_ver;    // Bits 10:8.
    logic [7:0] rsvd_7_0;
  } impcode_t;

  typedef union packed {
    logic [31:0] raw;
    impcode_t    imp;
  } scan_word_u;

  typedef struct packed {
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] ctl;
  } scan_out_t;

  typedef struct packed {
    logic update_data;
    logic update_addr;
    logic update_ctl;
  } scan_upd_t;

  typedef struct packed {
    logic [1:0] n_minus1;
    logic [1:0] m_log2;
    logic       asid16;
    logic       ej_dis;
  } cfg_t;

endpackage

// ==== source/ejtag_scan.sv ====
`timescale 1ns/1ps

module ejtag_scan (
  input  logic                  JTAG_CLOCK,
  input  logic                  RESET_D1_JR_N,
  input  tap_pkg::tap_ctl_t     ctl,
  input  logic [4:0]            ir,
  input  logic                  tdi,
  output logic                  escan_out,
  input  logic [31:0]           ejc_ctl,
  input  logic [31:0]           proc_data,
  input  logic [31:0]           proc_addr,
  input  logic [31:0]           dma_data,
  input  logic [31:0]           dma_addr,
  input  ejtag_pkg::cfg_t       cfg,
  output ejtag_pkg::scan_out_t  scan,
  output ejtag_pkg::scan_upd_t  upd,
  output logic                  pctrace_on
);

  ejtag_pkg::scan_word_u data_q, data_d;
  logic [31:0]           addr_q, addr_d;
  logic [31:0]           ctl_q, ctl_d;
  logic                  dmaacc;
  logic [31:0]           data_src;
  logic [31:0]           addr_src;

  assign dmaacc   = ejc_ctl[ejtag_pkg::CTL_DMAACC];
  assign data_src = dmaacc ? dma_data : proc_data;
  assign addr_src = dmaacc ? dma_addr : proc_addr;

  // ##########################################################
  // Capture, shift and update
  // ##########################################################

  always_comb begin
    data_d    = data_q;
    addr_d    = addr_q;
    ctl_d     = ctl_q;
    escan_out = 1'b0;
    upd       = '0;

    if (ctl.capture_dr) begin
      case (ir)
        ejtag_pkg::INS_IMPCODE: begin
          data_d.imp           = '0;
          data_d.imp.ejtag_ver = {1'b0, cfg.n_minus1};
          data_d.imp.m_log2    = {1'b0, cfg.m_log2};
          data_d.imp.one_16    = 1'b1;
          data_d.imp.one_23    = 1'b1;
          data_d.imp.ej_dis    = cfg.ej_dis;
          data_d.imp.asid16    = cfg.asid16;
        end
        ejtag_pkg::INS_DATA:    data_d.raw = data_src;
        ejtag_pkg::INS_ADDRESS: addr_d = addr_src;
        ejtag_pkg::INS_CONTROL: ctl_d = ejc_ctl;
        ejtag_pkg::INS_ALL: begin
          data_d.raw = data_src;
          addr_d     = addr_src;
          ctl_d      = ejc_ctl;
        end
        default: ;
      endcase
    end

    if (ctl.shift_dr) begin
      case (ir)
        ejtag_pkg::INS_IMPCODE,
        ejtag_pkg::INS_DATA:    {data_d.raw, escan_out} = {tdi, data_q.raw};
        ejtag_pkg::INS_ADDRESS: {addr_d, escan_out} = {tdi, addr_q};
        ejtag_pkg::INS_CONTROL: {ctl_d, escan_out} = {tdi, ctl_q};
        ejtag_pkg::INS_ALL: begin
          {addr_d, data_d.raw, ctl_d, escan_out} = {tdi, addr_q, data_q.raw, ctl_q};
        end
        default: ;
      endcase
    end

    if (ctl.update_dr) begin
      case (ir)
        ejtag_pkg::INS_DATA:    upd.update_data = 1'b1;
        ejtag_pkg::INS_ADDRESS: upd.update_addr = 1'b1;
        ejtag_pkg::INS_CONTROL: upd.update_ctl = 1'b1;
        ejtag_pkg::INS_ALL:     upd = '1;
        default: ;                                    // IMPCODE is read only.
      endcase
    end
  end

  always_ff @(posedge JTAG_CLOCK or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      data_q <= '0;
      addr_q <= '0;
      ctl_q  <= '0;
    end else begin
      data_q <= data_d;
      addr_q <= addr_d;
      ctl_q  <= ctl_d;
    end
  end

  assign scan.data  = data_q.raw;
  assign scan.addr  = addr_q;
  assign scan.ctl   = ctl_q;
  assign pctrace_on = ctl.run_test && (ir == ejtag_pkg::INS_PCTRACE);

  // Strobes come only from Update-DR and last a single cycle.
  a_upd_pulse: assert property (@(posedge JTAG_CLOCK) disable iff (!RESET_D1_JR_N)
    (|upd) |-> ctl.update_dr ##1 !(|upd));

endmodule

// ==== source/ejtag_top.sv ====
`timescale 1ns/1ps

module ejtag_top #(
  parameter logic [31:0] CTL_WRITE_MASK = 32'h0007_8000 // Includes DMA access, bit 17.
) (
  input  logic                  JTAG_CLOCK,
  input  logic                  RESET_D1_JR_N,
  input  logic                  tms,
  input  logic                  tdi,
  output logic                  tdo,
  input  logic [31:0]           proc_data,
  input  logic [31:0]           proc_addr,
  input  logic [31:0]           dma_data,
  input  logic [31:0]           dma_addr,
  input  logic [31:0]           proc_status,
  input  ejtag_pkg::cfg_t       cfg,
  output ejtag_pkg::scan_out_t  scan,
  output ejtag_pkg::scan_upd_t  upd,
  output logic [31:0]           ejc_ctl,
  output logic                  pctrace_on
);

  tap_pkg::tap_ctl_t             ctl;
  logic [tap_pkg::IR_WIDTH-1:0]  ir;
  logic                          escan_out;

  tap_controller i_tap_controller (
    .JTAG_CLOCK    (JTAG_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .tms           (tms),
    .ctl           (ctl)
  );

  tap_instruction i_tap_instruction (
    .JTAG_CLOCK    (JTAG_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .ctl           (ctl),
    .tdi           (tdi),
    .escan_out     (escan_out),
    .ir            (ir),
    .tdo           (tdo)
  );

  ejtag_scan i_ejtag_scan (
    .JTAG_CLOCK    (JTAG_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .ctl           (ctl),
    .ir            (ir),
    .tdi           (tdi),
    .escan_out     (escan_out),
    .ejc_ctl       (ejc_ctl),
    .proc_data     (proc_data),
    .proc_addr     (proc_addr),
    .dma_data      (dma_data),
    .dma_addr      (dma_addr),
    .cfg           (cfg),
    .scan          (scan),
    .upd           (upd),
    .pctrace_on    (pctrace_on)
  );

  ejtag_control_reg #(
    .CTL_WRITE_MASK (CTL_WRITE_MASK)
  ) i_ejtag_control_reg (
    .JTAG_CLOCK    (JTAG_CLOCK),
    .RESET_D1_JR_N (RESET_D1_JR_N),
    .upd           (upd),
    .scan_ctl      (scan.ctl),
    .proc_status   (proc_status),
    .ejc_ctl       (ejc_ctl)
  );

endmodule

// ==== source/tap_controller.sv ====
`timescale 1ns/1ps

module tap_controller (
  input  logic              JTAG_CLOCK,
  input  logic              RESET_D1_JR_N,
  input  logic              tms,
  output tap_pkg::tap_ctl_t ctl
);

  tap_pkg::tap_state_t state_q;
  tap_pkg::tap_state_t state_d;

  // ##########################################################
  // State register and 1149.1 transitions
  // ##########################################################

  always_comb begin
    state_d = state_q;
    case (state_q)
      tap_pkg::TAP_TEST_LOGIC_RESET:
        state_d = tms ? tap_pkg::TAP_TEST_LOGIC_RESET : tap_pkg::TAP_RUN_TEST_IDLE;
      tap_pkg::TAP_RUN_TEST_IDLE:
        state_d = tms ? tap_pkg::TAP_SELECT_DR : tap_pkg::TAP_RUN_TEST_IDLE;
      tap_pkg::TAP_SELECT_DR:
        state_d = tms ? tap_pkg::TAP_SELECT_IR : tap_pkg::TAP_CAPTURE_DR;
      tap_pkg::TAP_CAPTURE_DR:
        state_d = tms ? tap_pkg::TAP_EXIT1_DR : tap_pkg::TAP_SHIFT_DR;
      tap_pkg::TAP_SHIFT_DR:
        state_d = tms ? tap_pkg::TAP_EXIT1_DR : tap_pkg::TAP_SHIFT_DR;
      tap_pkg::TAP_EXIT1_DR:
        state_d = tms ? tap_pkg::TAP_UPDATE_DR : tap_pkg::TAP_PAUSE_DR;
      tap_pkg::TAP_PAUSE_DR:
        state_d = tms ? tap_pkg::TAP_EXIT2_DR : tap_pkg::TAP_PAUSE_DR;
      tap_pkg::TAP_EXIT2_DR:
        state_d = tms ? tap_pkg::TAP_UPDATE_DR : tap_pkg::TAP_SHIFT_DR;
      tap_pkg::TAP_UPDATE_DR:
        state_d = tms ? tap_pkg::TAP_SELECT_DR : tap_pkg::TAP_RUN_TEST_IDLE;
      tap_pkg::TAP_SELECT_IR:
        state_d = tms ? tap_pkg::TAP_TEST_LOGIC_RESET : tap_pkg::TAP_CAPTURE_IR;
      tap_pkg::TAP_CAPTURE_IR:
        state_d = tms ? tap_pkg::TAP_EXIT1_IR : tap_pkg::TAP_SHIFT_IR;
      tap_pkg::TAP_SHIFT_IR:
        state_d = tms ? tap_pkg::TAP_EXIT1_IR : tap_pkg::TAP_SHIFT_IR;
      tap_pkg::TAP_EXIT1_IR:
        state_d = tms ? tap_pkg::TAP_UPDATE_IR : tap_pkg::TAP_PAUSE_IR;
      tap_pkg::TAP_PAUSE_IR:
        state_d = tms ? tap_pkg::TAP_EXIT2_IR : tap_pkg::TAP_PAUSE_IR;
      tap_pkg::TAP_EXIT2_IR:
        state_d = tms ? tap_pkg::TAP_UPDATE_IR : tap_pkg::TAP_SHIFT_IR;
      tap_pkg::TAP_UPDATE_IR:
        state_d = tms ? tap_pkg::TAP_SELECT_DR : tap_pkg::TAP_RUN_TEST_IDLE;
      default:
        state_d = tap_pkg::TAP_TEST_LOGIC_RESET;
    endcase
  end

  always_ff @(posedge JTAG_CLOCK or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      state_q <= tap_pkg::TAP_TEST_LOGIC_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Control levels straight from the state.
  always_comb begin
    ctl                  = '0;
    ctl.capture_dr       = (state_q == tap_pkg::TAP_CAPTURE_DR);
    ctl.shift_dr         = (state_q == tap_pkg::TAP_SHIFT_DR);
    ctl.update_dr        = (state_q == tap_pkg::TAP_UPDATE_DR);
    ctl.capture_ir       = (state_q == tap_pkg::TAP_CAPTURE_IR);
    ctl.shift_ir         = (state_q == tap_pkg::TAP_SHIFT_IR);
    ctl.update_ir        = (state_q == tap_pkg::TAP_UPDATE_IR);
    ctl.run_test         = (state_q == tap_pkg::TAP_RUN_TEST_IDLE);
    ctl.test_logic_reset = (state_q == tap_pkg::TAP_TEST_LOGIC_RESET);
  end

  a_one_phase: assert property (@(posedge JTAG_CLOCK) disable iff (!RESET_D1_JR_N)
    $onehot0({ctl.capture_dr, ctl.shift_dr, ctl.update_dr,
              ctl.capture_ir, ctl.shift_ir, ctl.update_ir}));

endmodule

// ==== source/tap_instruction.sv ====
`timescale 1ns/1ps

module tap_instruction (
  input  logic                            JTAG_CLOCK,
  input  logic                            RESET_D1_JR_N,
  input  tap_pkg::tap_ctl_t               ctl,
  input  logic                            tdi,
  input  logic                            escan_out,
  output logic [tap_pkg::IR_WIDTH-1:0]    ir,
  output logic                            tdo
);

  logic [tap_pkg::IR_WIDTH-1:0] ir_shift;
  logic                         bypass_q;
  logic                         scan_ins;

  always_ff @(posedge JTAG_CLOCK or negedge RESET_D1_JR_N) begin
    if (!RESET_D1_JR_N) begin
      ir_shift <= '0;
      ir       <= ejtag_pkg::INS_IMPCODE;
      bypass_q <= 1'b0;
    end else begin
      if (ctl.capture_ir) begin
        ir_shift <= tap_pkg::IR_CAPTURE;
      end else if (ctl.shift_ir) begin
        ir_shift <= {tdi, ir_shift[tap_pkg::IR_WIDTH-1:1]}; // LSB leaves first.
      end
      if (ctl.test_logic_reset) begin
        ir <= ejtag_pkg::INS_IMPCODE;
      end else if (ctl.update_ir) begin
        ir <= ir_shift;
      end
      if (ctl.capture_dr) begin
        bypass_q <= 1'b0;
      end else if (ctl.shift_dr) begin
        bypass_q <= tdi;
      end
    end
  end

  // Instructions that own an EJTAG scan register. All others use bypass.
  assign scan_ins = ir inside {ejtag_pkg::INS_IMPCODE, ejtag_pkg::INS_ADDRESS,
                               ejtag_pkg::INS_DATA, ejtag_pkg::INS_CONTROL,
                               ejtag_pkg::INS_ALL};

  always_comb begin
    if (ctl.shift_ir) begin
      tdo = ir_shift[0];
    end else if (ctl.shift_dr) begin
      tdo = scan_ins ? escan_out : bypass_q;
    end else begin
      tdo = 1'b0;
    end
  end

  a_ir_stable: assert property (@(posedge JTAG_CLOCK) disable iff (!RESET_D1_JR_N)
    !$stable(ir) |-> $past(ctl.update_ir) || $past(ctl.test_logic_reset));

endmodule

// ==== source/tap_pkg.sv ====
package tap_pkg;

  // ##########################################################
  // TAP controller states in the standard 1149.1 encoding
  // ##########################################################

  typedef enum logic [3:0] {
    TAP_EXIT2_DR         = 4'h0,
    TAP_EXIT1_DR         = 4'h1,
    TAP_SHIFT_DR         = 4'h2,
    TAP_PAUSE_DR         = 4'h3,
    TAP_SELECT_IR        = 4'h4,
    TAP_UPDATE_DR        = 4'h5,
    TAP_CAPTURE_DR       = 4'h6,
    TAP_SELECT_DR        = 4'h7,
    TAP_EXIT2_IR         = 4'h8,
    TAP_EXIT1_IR         = 4'h9,
    TAP_SHIFT_IR         = 4'hA,
    TAP_PAUSE_IR         = 4'hB,
    TAP_RUN_TEST_IDLE    = 4'hC,
    TAP_UPDATE_IR        = 4'hD,
    TAP_CAPTURE_IR       = 4'hE,
    TAP_TEST_LOGIC_RESET = 4'hF
  } tap_state_t;

  // Per-state control levels seen by the scan paths.
  typedef struct packed {
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic run_test;
    logic test_logic_reset;
  } tap_ctl_t;

  localparam int IR_WIDTH = 5;

  localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 5'b00001; // Shifted out on every IR scan.

endpackage
